//--- design/lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// datapath word
`define LC3B_WORD_W     16

// lc3x multiply works on the low byte of each operand
`define LC3B_MULT_W     8

// shift amount field, low bits of operand b
`define LC3B_SHIFT_W    4

// one quotient bit per restoring step
`define LC3B_DIV_STEPS  16

`endif

//--- design/lc3b_pkg.sv
`include "lc3b_params.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

    typedef enum logic [2:0]
    {
        op_add,
        op_and,
        op_not,
        op_lshf,
        op_rshfl,
        op_rshfa,
        op_mult,    // lc3x extension
        op_div      // lc3x extension
    } lc3b_exec_op;

    typedef struct packed
    {
        logic n;
        logic z;
        logic p;
    } lc3b_nzp;

    typedef struct packed
    {
        lc3b_exec_op op;
        lc3b_word    a;
        lc3b_word    b;
    } lc3b_exec_req;

    typedef struct packed
    {
        lc3b_word result;
        lc3b_nzp  nzp;
    } lc3b_exec_rsp;

    typedef enum logic [1:0]
    {
        md_idle,
        md_busy,
        md_done
    } lc3b_md_state;

    typedef enum logic [1:0]
    {
        seq_idle,
        seq_wait,
        seq_ack
    } lc3b_seq_state;

endpackage : lc3b_pkg

//--- design/lc3b_alu.sv
`timescale 1ns/1ps
`include "lc3b_params.svh"

module lc3b_alu
    import lc3b_pkg::*;
(
    input  lc3b_exec_op op,
    input  lc3b_word    a,
    input  lc3b_word    b,
    output lc3b_word    f
);

    logic [`LC3B_SHIFT_W-1:0] shamt;

    assign shamt = b[`LC3B_SHIFT_W-1:0];    // imm4 field of the shift

    always_comb
    begin
        case (op)
            op_add:
            begin
                f = a + b;      // wraps, no carry out
            end
            op_and:
            begin
                f = a & b;
            end
            op_not:
            begin
                f = ~a;         // b unused here
            end
            op_lshf:
            begin
                f = a << shamt;
            end
            op_rshfl:
            begin
                f = a >> shamt;     // zero fill
            end
            op_rshfa:
            begin
                f = lc3b_word'($signed(a) >>> shamt);   // sign fill
            end
            default:
            begin
                // mult and div are handled by the muldiv unit
                f = '0;
            end
        endcase
    end

endmodule : lc3b_alu

//--- design/lc3b_muldiv.sv
`timescale 1ns/1ps
`include "lc3b_params.svh"

module lc3b_muldiv
    import lc3b_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  lc3b_exec_op op,
    input  lc3b_word    a,
    input  lc3b_word    b,
    output lc3b_word    result,
    output logic        done
);

    localparam int CNT_W = $clog2(`LC3B_DIV_STEPS + 1);

    lc3b_md_state state_q;
    logic [CNT_W-1:0] cnt_q;       // iteration counter
    logic [CNT_W-1:0] last_step;
    logic last;

    lc3b_exec_op md_op_q;
    lc3b_word acc_q;               // product, or dividend turning into quotient
    lc3b_word sh_q;                // multiplicand or divisor
    lc3b_word rem_q;               // partial remainder
    logic [`LC3B_MULT_W-1:0] mplier_q;

    logic [`LC3B_WORD_W:0] rem_shift;
    logic [`LC3B_WORD_W:0] trial;

    always_comb
    begin
        if (md_op_q == op_div)
            last_step = CNT_W'(`LC3B_DIV_STEPS - 1);
        else
            last_step = CNT_W'(`LC3B_MULT_W - 1);
        last = (cnt_q == last_step);

        // bring down the next dividend bit, then try the subtract
        rem_shift = {rem_q, acc_q[`LC3B_WORD_W-1]};
        trial = rem_shift - {1'b0, sh_q};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= md_idle;
            cnt_q <= '0;
        end
        else
        begin
            case (state_q)
                md_idle:
                begin
                    if (start)
                    begin
                        state_q <= md_busy;
                        cnt_q <= '0;
                    end
                end
                md_busy:
                begin
                    if (last)
                        state_q <= md_done;
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                default:
                begin
                    state_q <= md_idle;     // done lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == md_idle && start)
        begin
            md_op_q <= op;
            rem_q <= '0;
            if (op == op_div)
            begin
                acc_q <= a;
                sh_q <= b;
            end
            else
            begin
                acc_q <= '0;
                sh_q <= {{(`LC3B_WORD_W - `LC3B_MULT_W){1'b0}}, a[`LC3B_MULT_W-1:0]};
                mplier_q <= b[`LC3B_MULT_W-1:0];
            end
        end
        else if (state_q == md_busy)
        begin
            if (md_op_q == op_div)
            begin
                if (trial[`LC3B_WORD_W])
                begin
                    rem_q <= rem_shift[`LC3B_WORD_W-1:0];   // restore
                    acc_q <= {acc_q[`LC3B_WORD_W-2:0], 1'b0};
                end
                else
                begin
                    rem_q <= trial[`LC3B_WORD_W-1:0];
                    acc_q <= {acc_q[`LC3B_WORD_W-2:0], 1'b1};
                end
            end
            else
            begin
                if (mplier_q[0])
                    acc_q <= acc_q + sh_q;
                sh_q <= sh_q << 1;
                mplier_q <= mplier_q >> 1;
            end
        end
    end

    // a zero divisor never fails the trial, so the quotient ends as all ones
    assign result = acc_q;
    assign done = (state_q == md_done);

endmodule : lc3b_muldiv

//--- design/lc3b_exec_sequencer.sv
`timescale 1ns/1ps

module lc3b_exec_sequencer
    import lc3b_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req,
    input  lc3b_exec_req req_data,
    output logic         ack,
    output lc3b_exec_rsp rsp,
    output lc3b_exec_op  op,
    output lc3b_word     a,
    output lc3b_word     b,
    input  lc3b_word     alu_f,
    output logic         md_start,
    input  lc3b_word     md_result,
    input  logic         md_done
);

    lc3b_seq_state state_q;
    lc3b_seq_state state_d;
    logic req_q;            // registered req
    logic req_is_md;
    logic is_md;
    logic result_ready;
    lc3b_word result_sel;
    lc3b_nzp nzp_sel;

    always_comb
    begin
        req_is_md = (req_data.op == op_mult) || (req_data.op == op_div);
        is_md = (op == op_mult) || (op == op_div);
        result_ready = is_md ? md_done : 1'b1;     // alu settles in one cycle
        result_sel = is_md ? md_result : alu_f;

        // gencc
        nzp_sel.n = result_sel[$bits(lc3b_word)-1];
        nzp_sel.z = (result_sel == '0);
        nzp_sel.p = !nzp_sel.n && !nzp_sel.z;

        state_d = state_q;
        case (state_q)
            seq_idle:
            begin
                if (req_q)
                    state_d = seq_wait;
            end
            seq_wait:
            begin
                if (result_ready)
                    state_d = seq_ack;
            end
            seq_ack:
            begin
                if (!req_q)
                    state_d = seq_idle;     // four-phase return to zero
            end
            default:
            begin
                state_d = seq_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= seq_idle;
            req_q <= 1'b0;
            md_start <= 1'b0;
            rsp <= '0;
        end
        else
        begin
            state_q <= state_d;
            req_q <= req;
            md_start <= (state_q == seq_idle) && req_q && req_is_md;    // one cycle pulse
            if (state_q == seq_wait && result_ready)
            begin
                rsp.result <= result_sel;
                rsp.nzp <= nzp_sel;
            end
        end
    end

    // operand capture, held stable for alu and muldiv
    always_ff @(posedge clk)
    begin
        if (state_q == seq_idle && req_q)
        begin
            op <= req_data.op;
            a <= req_data.a;
            b <= req_data.b;
        end
    end

    assign ack = (state_q == seq_ack);

endmodule : lc3b_exec_sequencer

//--- design/lc3b_exec_unit.sv
`timescale 1ns/1ps

module lc3b_exec_unit
    import lc3b_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req,
    input  lc3b_exec_req req_data,
    output logic         ack,
    output lc3b_exec_rsp rsp
);

    lc3b_exec_op op;
    lc3b_word a;
    lc3b_word b;
    lc3b_word alu_f;
    lc3b_word md_result;
    logic md_start;
    logic md_done;

    lc3b_exec_sequencer sequencer
    (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .req_data(req_data),
        .ack(ack),
        .rsp(rsp),
        .op(op),
        .a(a),
        .b(b),
        .alu_f(alu_f),
        .md_start(md_start),
        .md_result(md_result),
        .md_done(md_done)
    );

    lc3b_alu alu
    (
        .op(op),
        .a(a),
        .b(b),
        .f(alu_f)
    );

    lc3b_muldiv muldiv
    (
        .clk(clk),
        .rst_n(rst_n),
        .start(md_start),
        .op(op),
        .a(a),
        .b(b),
        .result(md_result),
        .done(md_done)
    );

endmodule : lc3b_exec_unit

//--- sim/tb_lc3b_exec.sv
`timescale 1ns/1ps
`include "lc3b_params.svh"

module tb_lc3b_exec
    import lc3b_pkg::*;
;

    localparam int RAND_ALU = 8;        // random rounds of add, and, not
    localparam int RAND_MD = 8;         // random multiplies, random divides
    localparam int NUM_OPS = 31 + 3 * RAND_ALU + 2 * RAND_MD;   // 31 directed ops
    localparam int CYCLE_LIMIT = NUM_OPS * 24 + 100;
    localparam int ACK_LIMIT = 40;      // worst case divide is about 20 cycles

    logic         clk;
    logic         rst_n;
    logic         req;
    lc3b_exec_req req_data;
    logic         ack;
    lc3b_exec_rsp rsp;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    lc3b_exec_unit uut
    (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .req_data(req_data),
        .ack(ack),
        .rsp(rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reference model of the execute stage
    function automatic lc3b_word model_result(input lc3b_exec_op op, input lc3b_word a,
                                              input lc3b_word b);
        int amt;
        logic [2*`LC3B_WORD_W-1:0] sext;
        amt = b[`LC3B_SHIFT_W-1:0];
        sext = {{`LC3B_WORD_W{a[`LC3B_WORD_W-1]}}, a};
        case (op)
            op_add:   return a + b;
            op_and:   return a & b;
            op_not:   return ~a;
            op_lshf:  return a << amt;
            op_rshfl: return a >> amt;
            op_rshfa: return lc3b_word'(sext >> amt);
            op_mult:  return lc3b_word'(a[`LC3B_MULT_W-1:0]) * lc3b_word'(b[`LC3B_MULT_W-1:0]);
            op_div:   return (b == '0) ? 16'hffff : a / b;
            default:  return '0;
        endcase
    endfunction

    function automatic lc3b_nzp model_nzp(input lc3b_word w);
        lc3b_nzp f;
        f = '0;
        if (w == '0)
            f.z = 1'b1;
        else if (w[`LC3B_WORD_W-1])
            f.n = 1'b1;
        else
            f.p = 1'b1;
        return f;
    endfunction

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_nzp(input string name, input lc3b_nzp got, input lc3b_nzp exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic handshake_timeout(input string what, input logic level);
        error_count++;
        $display("Handshake stuck at %0t: ack did not go to %b during %s", $time, level, what);
    endtask

    // samples on the falling edge, away from the DUT's updates
    task automatic wait_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ack !== level && cycles < ACK_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level)
            handshake_timeout(what, level);
    endtask

    task automatic run_op(input lc3b_exec_op op, input lc3b_word a, input lc3b_word b,
                          input int hold_cycles);
        lc3b_word exp_word;
        exp_word = model_result(op, a, b);
        @(posedge clk);
        req <= 1'b1;
        req_data <= '{op, a, b};
        wait_ack(1'b1, op.name());
        check_word("rsp.result", rsp.result, exp_word);
        check_nzp("rsp.nzp", rsp.nzp, model_nzp(exp_word));
        repeat (hold_cycles)
        begin
            @(negedge clk);
            check_flag("ack", ack, 1'b1);       // back-pressure, unit must wait
            check_word("rsp.result", rsp.result, exp_word);
            check_nzp("rsp.nzp", rsp.nzp, model_nzp(exp_word));
        end
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0, op.name());
    endtask

    task automatic test_reset_state();
        repeat (3)
        begin
            @(negedge clk);
            check_flag("ack", ack, 1'b0);
            check_word("rsp.result", rsp.result, '0);
            check_nzp("rsp.nzp", rsp.nzp, '0);
        end
    endtask

    task automatic test_logic_ops();
        run_op(op_add, 16'h0001, 16'h0002, 0);
        run_op(op_add, 16'h7fff, 16'h0001, 0);     // overflow into negative
        run_op(op_add, 16'hffff, 16'h0001, 0);     // wraps to zero
        run_op(op_add, 16'h1234, 16'h0000, 0);
        run_op(op_add, 16'h8000, 16'h8000, 0);
        run_op(op_and, 16'hffff, 16'h0000, 0);
        run_op(op_and, 16'hf0f0, 16'hff00, 0);
        run_op(op_and, 16'h8000, 16'hffff, 0);
        run_op(op_not, 16'h0000, 16'h1111, 0);
        run_op(op_not, 16'hffff, 16'h0000, 0);
        run_op(op_not, 16'h00ff, 16'hffff, 0);
        repeat (RAND_ALU)
        begin
            run_op(op_add, lc3b_word'($urandom), lc3b_word'($urandom), 0);
            run_op(op_and, lc3b_word'($urandom), lc3b_word'($urandom), 0);
            run_op(op_not, lc3b_word'($urandom), lc3b_word'($urandom), 0);
        end
    endtask

    task automatic test_shifts();
        int amts[3] = '{0, 1, 15};
        foreach (amts[i])
        begin
            // upper bits of b are junk, only the low field counts
            run_op(op_lshf, 16'h8421, {12'h5a5, 4'(amts[i])}, 0);
            run_op(op_rshfl, 16'h8421, {12'h5a5, 4'(amts[i])}, 0);
            run_op(op_rshfa, 16'h8421, {12'h5a5, 4'(amts[i])}, 0);
        end
        run_op(op_rshfa, 16'h4321, 16'h0001, 0);   // positive, zero fill
    endtask

    task automatic test_multiply();
        run_op(op_mult, 16'h00ff, 16'h00ff, 0);
        run_op(op_mult, 16'h1203, 16'h3405, 0);    // upper bytes ignored
        repeat (RAND_MD)
            run_op(op_mult, lc3b_word'($urandom), lc3b_word'($urandom), 0);
    endtask

    task automatic test_divide();
        run_op(op_div, 16'd100, 16'd7, 0);
        run_op(op_div, 16'h1234, 16'h0000, 0);     // divide by zero
        run_op(op_div, 16'h0000, 16'h0005, 0);
        run_op(op_div, 16'hffff, 16'h0001, 0);     // negative looking quotient
        repeat (RAND_MD)
            run_op(op_div, lc3b_word'($urandom), lc3b_word'($urandom_range(16'h0fff, 0)), 0);
    endtask

    task automatic test_handshake();
        run_op(op_add, 16'h4000, 16'h4000, 10);
        run_op(op_mult, 16'hab80, 16'hcd02, 10);
        run_op(op_div, 16'hc350, 16'h0019, 10);
        run_op(op_rshfa, 16'hf000, 16'h0004, 10);
    endtask

    // run length guard
    initial
    begin
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'he613dc40));
        rst_n = 1'b0;
        req = 1'b0;
        req_data = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_logic_ops();
        test_shifts();
        test_multiply();
        test_divide();
        test_handshake();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule : tb_lc3b_exec

//--- flist.f
+incdir+design
design/lc3b_pkg.sv
design/lc3b_alu.sv
design/lc3b_muldiv.sv
design/lc3b_exec_sequencer.sv
design/lc3b_exec_unit.sv
sim/tb_lc3b_exec.sv

//--- Bender.yml
package:
  name: lc3b_exec

sources:
  - include_dirs:
      - design
    files:
      - design/lc3b_pkg.sv
      - design/lc3b_alu.sv
      - design/lc3b_muldiv.sv
      - design/lc3b_exec_sequencer.sv
      - design/lc3b_exec_unit.sv
      - target: simulation
        files:
          - sim/tb_lc3b_exec.sv
